// ==== build.f ====
+incdir+sim
verilog/mmu_pkg.sv
verilog/tlb_bank.sv
verilog/tlb_hit_select.sv
verilog/page_walker.sv
verilog/mmu_top.sv
sim/tb_mmu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the MMU testbench with Verilator, runs it and looks for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_mmu -f build.f

output=$(./obj_dir/Vtb_mmu 2>&1 || true)
echo "$output"

if grep -q "Regression passed" <<< "$output"; then
    exit 0
fi
exit 1

// ==== sim/tb_mmu_model.svh ====
// Page-table model for the Sv39 translator testbench
// Sparse PTE memory with random leaves and a reference walk
`ifndef TB_MMU_MODEL_SVH
`define TB_MMU_MODEL_SVH

localparam logic [mmu_pkg::PPN_W-1:0] ROOT_PPN = 44'h100;

logic [mmu_pkg::PTE_W-1:0]  pt_mem [logic [mmu_pkg::PA_W-1:0]];    // PTE by physical address
bit                         bad_addr [logic [mmu_pkg::PA_W-1:0]];  // Reads that access-fault
logic [mmu_pkg::VA_W-1:0]   mapped_va [$];

function automatic logic [mmu_pkg::PA_W-1:0] pte_addr(input logic [mmu_pkg::PPN_W-1:0] ppn,
                                                      input logic [mmu_pkg::VA_W-1:0] va,
                                                      input int lvl);
    return {ppn, va[mmu_pkg::PAGE_OFF_W + mmu_pkg::LEVEL_BITS*lvl +: mmu_pkg::LEVEL_BITS], 3'b000};
endfunction

function automatic logic [mmu_pkg::PTE_W-1:0] read_pte(input logic [mmu_pkg::PA_W-1:0] addr);
    return pt_mem.exists(addr) ? pt_mem[addr] : 64'd0;     // Unmapped memory reads as invalid
endfunction

function automatic void build_table();
    logic [mmu_pkg::VA_W-1:0]  va;
    logic [mmu_pkg::PPN_W-1:0] ppn;
    logic [mmu_pkg::PPN_W-1:0] next_ppn;
    logic [mmu_pkg::PA_W-1:0]  addr;
    logic [mmu_pkg::PTE_W-1:0] pte;
    logic [7:0]                flags;
    int                        lvl;
    int                        kind;
    bit                        ok;
    next_ppn = ROOT_PPN + 44'd1;
    for (int tries = 0; tries < 1000 && mapped_va.size() < 32; tries++) begin
        va  = mmu_pkg::VA_W'({$urandom, $urandom});
        lvl = $urandom_range(2, 0);
        ppn = ROOT_PPN;
        ok  = 1'b1;
        for (int l = 2; l > lvl && ok; l--) begin
            addr = pte_addr(ppn, va, l);
            if (!pt_mem.exists(addr)) begin
                pt_mem[addr] = {10'd0, next_ppn, 10'h001};     // Pointer to a fresh table
                next_ppn     = next_ppn + 44'd1;
            end
            pte = pt_mem[addr];
            ok  = (pte[3:0] == 4'b0001);                       // A leaf above blocks this page
            ppn = pte[53:10];
        end
        addr = pte_addr(ppn, va, lvl);
        if (ok && !pt_mem.exists(addr)) begin
            kind = $urandom_range(9, 0);
            case (kind)
                0:          flags = {7'($urandom), 1'b0};      // Invalid
                1:          flags = {5'($urandom), 3'b101};    // W without R
                2:          flags = {4'($urandom), 4'b0001};   // Pointer in leaf position
                3, 4, 5, 6: flags = 8'hcf;
                default:    flags = {7'($urandom), 1'b1};
            endcase
            if (kind == 3) bad_addr[addr] = 1'b1;
            pt_mem[addr] = {10'd0, mmu_pkg::PPN_W'($urandom), 2'b00, flags};
            mapped_va.push_back(va);
        end
    end
endfunction

// A and the bit for the access kind must be set, stores also need D
function automatic bit access_denied(input logic [7:0] flags, input mmu_pkg::access_e acc);
    if (!flags[6]) return 1'b1;
    if (acc == mmu_pkg::ACC_FETCH) return !flags[3];
    if (acc == mmu_pkg::ACC_LOAD) return !flags[1];
    return !(flags[2] && flags[7]);
endfunction

function automatic logic [mmu_pkg::PA_W-1:0] leaf_pa(input logic [mmu_pkg::PPN_W-1:0] ppn,
                                                     input logic [mmu_pkg::VA_W-1:0] va,
                                                     input int lvl);
    logic [mmu_pkg::PA_W-1:0] pa;
    pa = {ppn, va[11:0]};
    if (lvl >= 1) pa[20:12] = va[20:12];                   // 2 MB offset
    if (lvl == 2) pa[29:21] = va[29:21];                   // 1 GB offset
    return pa;
endfunction

// Reference walk, leaves the PTE addresses it reads in expected_reads
function automatic mmu_pkg::core_resp_t model_walk(input logic [mmu_pkg::VA_W-1:0] va,
                                                   input mmu_pkg::access_e acc);
    mmu_pkg::core_resp_t       resp;
    logic [mmu_pkg::PPN_W-1:0] ppn;
    logic [mmu_pkg::PA_W-1:0]  addr;
    logic [mmu_pkg::PTE_W-1:0] pte;
    resp = '0;
    ppn  = ROOT_PPN;
    expected_reads.delete();
    for (int l = 2; l >= 0; l--) begin
        addr = pte_addr(ppn, va, l);
        pte  = read_pte(addr);
        expected_reads.push_back(addr);
        if (bad_addr.exists(addr)) begin
            resp.access_fault = 1'b1;
            return resp;
        end
        if (!pte[0] || (!pte[1] && pte[2])) begin
            resp.page_fault = 1'b1;
            return resp;
        end
        if (pte[3:1] != 3'b000) begin
            resp.page_fault = access_denied(pte[7:0], acc);
            if (!resp.page_fault) resp.pa = leaf_pa(pte[53:10], va, l);
            return resp;
        end
        ppn = pte[53:10];
    end
    resp.page_fault = 1'b1;                                // Pointer at level 0
    return resp;
endfunction

function automatic void rewrite_leaf(input logic [mmu_pkg::VA_W-1:0] va,
                                     input mmu_pkg::access_e acc);
    logic [mmu_pkg::PA_W-1:0]  leaf;
    logic [mmu_pkg::PTE_W-1:0] pte;
    void'(model_walk(va, acc));
    leaf       = expected_reads[$];
    pte        = pt_mem[leaf];
    pte[53:10] = pte[53:10] + 44'h10_0000;                 // New frame differs above bit 30
    pt_mem[leaf] = pte;
endfunction

`endif

// ==== sim/tb_mmu.sv ====
// Testbench for the Sv39 address translator
// Random translations checked against a page-table model, random PTE memory latency
`timescale 1ns/100ps

module tb_mmu;

    localparam int TIMEOUT = 200;

    logic                           i_clk;
    logic                           i_nrst;
    logic                           i_req_valid;
    logic                           o_req_ready;
    mmu_pkg::core_req_t             i_req;
    logic                           o_resp_valid;
    logic                           i_resp_ready;
    mmu_pkg::core_resp_t            o_resp;
    logic                           o_mem_req_valid;
    logic                           i_mem_req_ready;
    logic [mmu_pkg::PA_W-1:0]       o_mem_req_addr;
    logic                           i_mem_resp_valid;
    logic [mmu_pkg::PTE_W-1:0]      i_mem_resp_data;
    logic                           i_mem_resp_fault;
    logic                           i_mmu_ena;
    logic [mmu_pkg::PPN_W-1:0]      i_satp_ppn;
    logic                           i_fence;
    int                             mem_reads = 0;      // PTE reads since the last accept
    logic [mmu_pkg::PA_W-1:0]       expected_reads [$];

    `include "tb_mmu_model.svh"

    mmu_top dut_i (.*);

    initial i_clk = 1'b0;
    always #2 i_clk = ~i_clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_resp(input mmu_pkg::core_resp_t got, input mmu_pkg::core_resp_t want);
        if (got !== want) begin
            abort_run($sformatf("Fail at %0t: response pa %h pf %b af %b, expected pa %h pf %b af %b",
                $time, got.pa, got.page_fault, got.access_fault,
                want.pa, want.page_fault, want.access_fault));
        end
    endtask

    task automatic check_pa(input logic [mmu_pkg::PA_W-1:0] got,
                            input logic [mmu_pkg::PA_W-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("Fail at %0t: PTE read at %h, expected %h", $time, got, want));
        end
    endtask

    function automatic mmu_pkg::access_e random_acc();
        return mmu_pkg::access_e'(2'($urandom_range(2, 0)));
    endfunction

    // Back-pressure about one cycle in four
    always @(posedge i_clk) begin
        #0.5;
        i_resp_ready    = ($urandom_range(3, 0) != 0);
        i_mem_req_ready = ($urandom_range(3, 0) != 0);
    end

    // PTE memory answers each accepted read 0 to 3 cycles later
    initial begin : mem_responder
        logic [mmu_pkg::PA_W-1:0] addr;
        int                       delay;
        forever begin
            @(negedge i_clk);
            if (i_nrst && o_mem_req_valid && i_mem_req_ready) begin
                addr = o_mem_req_addr;
                mem_reads++;
                if (expected_reads.size() == 0)
                    abort_run("DUT read a PTE that the walk does not need");
                check_pa(addr, expected_reads.pop_front());
                delay = $urandom_range(3, 0);
                repeat (delay + 1) @(posedge i_clk);
                #0.5;
                i_mem_resp_valid = 1'b1;
                i_mem_resp_data  = read_pte(addr);
                i_mem_resp_fault = (bad_addr.exists(addr) != 0);
                @(posedge i_clk);
                #0.5;
                i_mem_resp_valid = 1'b0;
            end
        end
    end

    task automatic translate(input logic [mmu_pkg::VA_W-1:0] va, input mmu_pkg::access_e acc,
                             input bit expect_hit, input bit expect_walk, output bit ok);
        mmu_pkg::core_resp_t want;
        bit                  seen;
        bit                  done;
        int                  cycles;
        want = model_walk(va, acc);
        if (!i_mmu_ena) begin
            want    = '0;
            want.pa = mmu_pkg::PA_W'(va);
            expected_reads.delete();
        end
        ok          = !want.page_fault && !want.access_fault;
        i_req_valid = 1'b1;
        i_req       = '{va: va, acc: acc};
        done        = 1'b0;
        for (cycles = 0; !done; cycles++) begin
            if (cycles == TIMEOUT) abort_run("DUT did not accept the request in time");
            @(negedge i_clk);
            done = o_req_ready;
            @(posedge i_clk);
            #0.5;
        end
        i_req_valid = 1'b0;
        mem_reads   = 0;
        seen        = 1'b0;
        done        = 1'b0;
        for (cycles = 1; !done; cycles++) begin             // Cycle 1 is the lookup
            if (cycles > TIMEOUT) abort_run("DUT did not answer the request in time");
            @(negedge i_clk);
            if (o_resp_valid) begin
                check_resp(o_resp, want);
                if (!seen && expect_hit && cycles != 2)
                    abort_run($sformatf("Fail at %0t: hit answered after %0d cycles", $time, cycles));
                seen = 1'b1;
            end
            done = o_resp_valid && i_resp_ready;
            @(posedge i_clk);
            #0.5;
        end
        if (expect_hit && mem_reads != 0)
            abort_run($sformatf("Fail at %0t: repeated access read the page table", $time));
        if (expect_walk && mem_reads == 0)
            abort_run($sformatf("Fail at %0t: no page walk after the fence", $time));
        if (mem_reads != 0 && expected_reads.size() != 0)
            abort_run($sformatf("Fail at %0t: walk ended before its last PTE read", $time));
    endtask

    task automatic pulse_fence();
        i_fence = 1'b1;
        @(posedge i_clk);
        #0.5;
        i_fence = 1'b0;
    endtask

    initial begin
        logic [mmu_pkg::VA_W-1:0] va;
        mmu_pkg::access_e         acc;
        bit                       ok;
        int                       since_fence;
        void'($urandom(32'h9c0d));
        i_nrst           = 1'b0;
        i_req_valid      = 1'b0;
        i_req            = '0;
        i_resp_ready     = 1'b0;
        i_mem_req_ready  = 1'b0;
        i_mem_resp_valid = 1'b0;
        i_mem_resp_data  = '0;
        i_mem_resp_fault = 1'b0;
        i_mmu_ena        = 1'b0;
        i_satp_ppn       = ROOT_PPN;
        i_fence          = 1'b0;
        build_table();
        repeat (4) @(posedge i_clk);
        #0.5;
        i_nrst = 1'b1;
        @(negedge i_clk);
        if (!o_req_ready || o_resp_valid || o_mem_req_valid)
            abort_run("DUT outputs wrong after reset");
        @(posedge i_clk);
        #0.5;

        // Bare mode answers like a hit
        repeat (20) begin
            translate(mmu_pkg::VA_W'({$urandom, $urandom}), random_acc(), 1'b1, 1'b0, ok);
        end

        i_mmu_ena   = 1'b1;
        since_fence = 0;
        repeat (300) begin
            va       = mapped_va[$urandom_range(mapped_va.size() - 1, 0)];
            va[11:0] = 12'($urandom);
            acc      = random_acc();
            translate(va, acc, 1'b0, 1'b0, ok);
            if (ok) begin
                va[11:0] = 12'($urandom);                   // Same page, now cached
                translate(va, random_acc(), 1'b1, 1'b0, ok);
                if (since_fence >= 40) begin
                    rewrite_leaf(va, acc);
                    pulse_fence();
                    translate(va, acc, 1'b0, 1'b1, ok);
                    since_fence = 0;
                end
            end
            since_fence++;
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== verilog/mmu_top.sv ====
// Sv39 address translator top
// Page walker, one TLB bank per page size and the hit selector
`timescale 1ns/100ps

module mmu_top (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    input  mmu_pkg::core_req_t          i_req,
    output logic                        o_resp_valid,
    input  logic                        i_resp_ready,
    output mmu_pkg::core_resp_t         o_resp,
    output logic                        o_mem_req_valid,
    input  logic                        i_mem_req_ready,
    output logic [mmu_pkg::PA_W-1:0]    o_mem_req_addr,
    input  logic                        i_mem_resp_valid,
    input  logic [mmu_pkg::PTE_W-1:0]   i_mem_resp_data,
    input  logic                        i_mem_resp_fault,
    input  logic                        i_mmu_ena,
    input  logic [mmu_pkg::PPN_W-1:0]   i_satp_ppn,
    input  logic                        i_fence
);

    logic [mmu_pkg::VA_W-1:0]                   lookup_va;
    mmu_pkg::access_e                           lookup_acc;
    mmu_pkg::tlb_hit_t [mmu_pkg::LEVELS-1:0]    tlb_hits;  // Indexed by page level
    logic                                       tlb_hit;
    logic [mmu_pkg::PA_W-1:0]                   tlb_pa;
    logic                                       tlb_fault;
    mmu_pkg::tlb_fill_t                         tlb_fill;

    page_walker walker_i (
        .i_clk            (i_clk),
        .i_nrst           (i_nrst),
        .i_req_valid      (i_req_valid),
        .o_req_ready      (o_req_ready),
        .i_req            (i_req),
        .o_resp_valid     (o_resp_valid),
        .i_resp_ready     (i_resp_ready),
        .o_resp           (o_resp),
        .o_mem_req_valid  (o_mem_req_valid),
        .i_mem_req_ready  (i_mem_req_ready),
        .o_mem_req_addr   (o_mem_req_addr),
        .i_mem_resp_valid (i_mem_resp_valid),
        .i_mem_resp_data  (i_mem_resp_data),
        .i_mem_resp_fault (i_mem_resp_fault),
        .i_mmu_ena        (i_mmu_ena),
        .i_satp_ppn       (i_satp_ppn),
        .o_lookup_va      (lookup_va),
        .o_lookup_acc     (lookup_acc),
        .i_tlb_hit        (tlb_hit),
        .i_tlb_pa         (tlb_pa),
        .i_tlb_fault      (tlb_fault),
        .o_fill           (tlb_fill)
    );

    // 4 KB, 2 MB and 1 GB banks
    for (genvar l = 0; l < mmu_pkg::LEVELS; l++) begin : bank_g
        tlb_bank #(.LEVEL(l)) bank_i (
            .i_clk       (i_clk),
            .i_nrst      (i_nrst),
            .i_fence     (i_fence),
            .i_lookup_va (lookup_va),
            .i_fill      (tlb_fill),
            .o_hit       (tlb_hits[l])
        );
    end

    tlb_hit_select hit_sel_i (
        .i_hits  (tlb_hits),
        .i_va    (lookup_va),
        .i_acc   (lookup_acc),
        .o_hit   (tlb_hit),
        .o_pa    (tlb_pa),
        .o_fault (tlb_fault)
    );

endmodule

// ==== verilog/page_walker.sv ====
// Sv39 page walker
// Runs one translation at a time: TLB lookup, up to three PTE reads,
// leaf checks and the TLB fill
`timescale 1ns/100ps

module page_walker (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_req_valid,
    output logic                        o_req_ready,
    input  mmu_pkg::core_req_t          i_req,
    output logic                        o_resp_valid,
    input  logic                        i_resp_ready,
    output mmu_pkg::core_resp_t         o_resp,
    output logic                        o_mem_req_valid,
    input  logic                        i_mem_req_ready,
    output logic [mmu_pkg::PA_W-1:0]    o_mem_req_addr,
    input  logic                        i_mem_resp_valid,
    input  logic [mmu_pkg::PTE_W-1:0]   i_mem_resp_data,
    input  logic                        i_mem_resp_fault,
    input  logic                        i_mmu_ena,
    input  logic [mmu_pkg::PPN_W-1:0]   i_satp_ppn,
    output logic [mmu_pkg::VA_W-1:0]    o_lookup_va,
    output mmu_pkg::access_e            o_lookup_acc,
    input  logic                        i_tlb_hit,
    input  logic [mmu_pkg::PA_W-1:0]    i_tlb_pa,
    input  logic                        i_tlb_fault,
    output mmu_pkg::tlb_fill_t          o_fill
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_LOOKUP, ST_MEM_REQ, ST_MEM_WAIT, ST_HANDLE, ST_RESP
    } state_e;

    state_e                         state_q, state_d;
    mmu_pkg::core_req_t             req_q, req_d;
    logic                           xlate_q, xlate_d;       // Translation on for this request
    logic [1:0]                     level_q, level_d;
    logic [mmu_pkg::PA_W-1:0]       mem_addr_q, mem_addr_d;
    logic [mmu_pkg::PTE_W-1:0]      pte_q, pte_d;
    logic                           mem_fault_q, mem_fault_d;
    mmu_pkg::core_resp_t            resp_q, resp_d;

    logic [mmu_pkg::PPN_W-1:0]      pte_ppn;
    logic                           pte_bad;
    logic                           pte_ptr;
    logic                           leaf_fault;
    logic [1:0]                     next_level;

    // PTE decode
    assign pte_ppn    = pte_q[10 +: mmu_pkg::PPN_W];
    assign pte_bad    = !pte_q[mmu_pkg::PTE_V] ||
                        (!pte_q[mmu_pkg::PTE_R] && pte_q[mmu_pkg::PTE_W_BIT]);
    assign pte_ptr    = !pte_q[mmu_pkg::PTE_R] && !pte_q[mmu_pkg::PTE_W_BIT] &&
                        !pte_q[mmu_pkg::PTE_X];
    assign leaf_fault = mmu_pkg::perm_fault(pte_q[7:0], req_q.acc);
    assign next_level = level_q - 2'd1;

    assign o_req_ready     = (state_q == ST_IDLE);
    assign o_resp_valid    = (state_q == ST_RESP);
    assign o_resp          = resp_q;
    assign o_mem_req_valid = (state_q == ST_MEM_REQ);
    assign o_mem_req_addr  = mem_addr_q;
    assign o_lookup_va     = req_q.va;
    assign o_lookup_acc    = req_q.acc;

    // Fill pulses in the single HandleResp cycle of a good leaf
    assign o_fill.valid      = (state_q == ST_HANDLE) && !mem_fault_q && !pte_bad &&
                               !pte_ptr && !leaf_fault;
    assign o_fill.level      = level_q;
    assign o_fill.entry.vpn  = req_q.va[mmu_pkg::VA_W-1:mmu_pkg::PAGE_OFF_W];
    assign o_fill.entry.ppn  = pte_ppn;
    assign o_fill.entry.perm = pte_q[7:0];

    always_comb begin
        state_d     = state_q;
        req_d       = req_q;
        xlate_d     = xlate_q;
        level_d     = level_q;
        mem_addr_d  = mem_addr_q;
        pte_d       = pte_q;
        mem_fault_d = mem_fault_q;
        resp_d      = resp_q;
        case (state_q)
            ST_IDLE: begin
                if (i_req_valid) begin
                    req_d   = i_req;
                    xlate_d = i_mmu_ena;
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                resp_d  = '0;
                state_d = ST_RESP;
                if (!xlate_q) begin
                    resp_d.pa = mmu_pkg::PA_W'(req_q.va);                  // Bare mode
                end else if (i_tlb_hit) begin
                    resp_d.page_fault = i_tlb_fault;
                    if (!i_tlb_fault) resp_d.pa = i_tlb_pa;                // A fault carries no address
                end else begin
                    // Miss: root table entry for vpn[2]
                    level_d    = 2'd2;
                    mem_addr_d = {i_satp_ppn, req_q.va[mmu_pkg::VA_W-1 -: mmu_pkg::LEVEL_BITS],
                                  3'b000};
                    state_d    = ST_MEM_REQ;
                end
            end
            ST_MEM_REQ: begin
                if (i_mem_req_ready) state_d = ST_MEM_WAIT;
            end
            ST_MEM_WAIT: begin
                if (i_mem_resp_valid) begin
                    pte_d       = i_mem_resp_data;
                    mem_fault_d = i_mem_resp_fault;
                    state_d     = ST_HANDLE;
                end
            end
            ST_HANDLE: begin
                resp_d  = '0;
                state_d = ST_RESP;
                if (mem_fault_q) begin
                    resp_d.access_fault = 1'b1;
                end else if (pte_bad) begin
                    resp_d.page_fault = 1'b1;
                end else if (pte_ptr) begin
                    if (level_q == 2'd0) begin
                        resp_d.page_fault = 1'b1;                           // No level left
                    end else begin
                        level_d    = next_level;
                        mem_addr_d = {pte_ppn, req_q.va[mmu_pkg::PAGE_OFF_W +
                                      mmu_pkg::LEVEL_BITS*next_level +: mmu_pkg::LEVEL_BITS], 3'b000};
                        state_d    = ST_MEM_REQ;
                    end
                end else if (leaf_fault) begin
                    resp_d.page_fault = 1'b1;
                end else begin
                    resp_d.pa = mmu_pkg::compose_pa(pte_ppn, req_q.va, level_q);
                end
            end
            ST_RESP: begin
                if (i_resp_ready) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        req_q       <= req_d;
        xlate_q     <= xlate_d;
        level_q     <= level_d;
        mem_addr_q  <= mem_addr_d;
        pte_q       <= pte_d;
        mem_fault_q <= mem_fault_d;
        resp_q      <= resp_d;
    end

    a_mem_req_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_mem_req_valid && !i_mem_req_ready |=> o_mem_req_valid && $stable(o_mem_req_addr))
        else $error("PTE read request dropped before accept");

    // Response holds under back-pressure
    a_resp_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp))
        else $error("Response dropped before accept");

endmodule

// ==== verilog/tlb_hit_select.sv ====
// TLB hit selector
// Chooses the hitting bank, builds the physical address and checks permission
`timescale 1ns/100ps

module tlb_hit_select (
    input  mmu_pkg::tlb_hit_t [mmu_pkg::LEVELS-1:0] i_hits,
    input  logic [mmu_pkg::VA_W-1:0]                i_va,
    input  mmu_pkg::access_e                        i_acc,
    output logic                                    o_hit,
    output logic [mmu_pkg::PA_W-1:0]                o_pa,
    output logic                                    o_fault
);

    logic [mmu_pkg::LEVELS-1:0]  hit_vec;
    logic [1:0]                  sel_level;
    mmu_pkg::tlb_entry_t         sel_entry;

    // Scan from the top so the smallest hitting page is the last one kept
    always_comb begin
        hit_vec   = '0;
        sel_level = 2'd0;
        sel_entry = i_hits[0].entry;
        for (int l = mmu_pkg::LEVELS - 1; l >= 0; l--) begin
            hit_vec[l] = i_hits[l].hit;
            if (i_hits[l].hit) begin
                sel_level = 2'(l);
                sel_entry = i_hits[l].entry;
            end
        end
    end

    assign o_hit   = |hit_vec;
    assign o_pa    = mmu_pkg::compose_pa(sel_entry.ppn, i_va, sel_level);
    assign o_fault = o_hit && mmu_pkg::perm_fault(sel_entry.perm, i_acc);   // Hits are checked too

    // Banks are filled from disjoint leaves, so overlapping hits mean stale entries
    always_comb begin
        a_one_hit: assert final ($isunknown(hit_vec) || $onehot0(hit_vec))
            else $error("More than one TLB bank hits");
    end

endmodule

// ==== verilog/tlb_bank.sv ====
// Direct-mapped TLB bank for one page size
// Lookup is combinational, fills and fences take effect at the next edge
`timescale 1ns/100ps

module tlb_bank #(
    parameter int LEVEL = 0                         // 0: 4 KB, 1: 2 MB, 2: 1 GB
) (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  logic                        i_fence,
    input  logic [mmu_pkg::VA_W-1:0]    i_lookup_va,
    input  mmu_pkg::tlb_fill_t          i_fill,
    output mmu_pkg::tlb_hit_t           o_hit
);

    logic [mmu_pkg::VPN_W-1:0]           lookup_vpn;
    logic [mmu_pkg::TLB_IDX_W-1:0]       lookup_idx;
    logic [mmu_pkg::TLB_IDX_W-1:0]       fill_idx;
    logic                                fill_we;
    logic [2**mmu_pkg::TLB_IDX_W-1:0]    valid_q;
    mmu_pkg::tlb_entry_t                 entry_mem [2**mmu_pkg::TLB_IDX_W];

    // Index sits just above this level's page offset
    assign lookup_vpn = i_lookup_va[mmu_pkg::VA_W-1:mmu_pkg::PAGE_OFF_W];
    assign lookup_idx = lookup_vpn[LEVEL*mmu_pkg::LEVEL_BITS +: mmu_pkg::TLB_IDX_W];
    assign fill_idx   = i_fill.entry.vpn[LEVEL*mmu_pkg::LEVEL_BITS +: mmu_pkg::TLB_IDX_W];
    assign fill_we    = i_fill.valid && (i_fill.level == 2'(LEVEL)) && !i_fence;

    assign o_hit.entry = entry_mem[lookup_idx];
    assign o_hit.hit   = valid_q[lookup_idx] &&
        (entry_mem[lookup_idx].vpn[mmu_pkg::VPN_W-1:LEVEL*mmu_pkg::LEVEL_BITS] ==
         lookup_vpn[mmu_pkg::VPN_W-1:LEVEL*mmu_pkg::LEVEL_BITS]);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            valid_q <= '0;
        end else if (i_fence) begin
            valid_q <= '0;                          // Fence wins over a fill
        end else if (fill_we) begin
            valid_q[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (fill_we) begin
            entry_mem[fill_idx] <= i_fill.entry;
        end
    end

    a_fill_level: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_fill.valid |-> (i_fill.level < 2'(mmu_pkg::LEVELS)))
        else $error("TLB fill with level above 2");

endmodule

// ==== verilog/mmu_pkg.sv ====
// Sv39 MMU shared definitions
// Address widths, PTE flag positions, TLB structs and permission helpers
package mmu_pkg;

    localparam int VA_W       = 39;
    localparam int PA_W       = 56;
    localparam int PPN_W      = 44;
    localparam int VPN_W      = 27;
    localparam int PAGE_OFF_W = 12;
    localparam int LEVEL_BITS = 9;                  // VPN slice per level
    localparam int LEVELS     = 3;
    localparam int TLB_IDX_W  = 4;                  // 16 entries per bank
    localparam int PTE_W      = 64;

    // PTE flag positions
    localparam int PTE_V     = 0;
    localparam int PTE_R     = 1;
    localparam int PTE_W_BIT = 2;
    localparam int PTE_X     = 3;
    localparam int PTE_U     = 4;
    localparam int PTE_G     = 5;
    localparam int PTE_A     = 6;
    localparam int PTE_D     = 7;

    typedef enum logic [1:0] {
        ACC_FETCH = 2'd0,
        ACC_LOAD  = 2'd1,
        ACC_STORE = 2'd2
    } access_e;

    typedef struct packed {
        logic [VA_W-1:0] va;
        access_e         acc;
    } core_req_t;

    typedef struct packed {
        logic [PA_W-1:0] pa;
        logic            page_fault;
        logic            access_fault;
    } core_resp_t;

    typedef struct packed {
        logic [VPN_W-1:0] vpn;
        logic [PPN_W-1:0] ppn;
        logic [7:0]       perm;                     // PTE bits 7..0
    } tlb_entry_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] level;
        tlb_entry_t entry;
    } tlb_fill_t;

    typedef struct packed {
        logic       hit;
        tlb_entry_t entry;
    } tlb_hit_t;

    // True when the leaf permissions deny this access kind
    function automatic logic perm_fault(input logic [7:0] perm, input access_e acc);
        logic fault;
        fault = !perm[PTE_A];
        case (acc)
            ACC_FETCH: fault = fault || !perm[PTE_X];
            ACC_LOAD:  fault = fault || !perm[PTE_R];
            default:   fault = fault || !perm[PTE_W_BIT] || !perm[PTE_D];
        endcase
        return fault;
    endfunction

    // Superpages keep 9 more VA bits per level below the PPN
    function automatic logic [PA_W-1:0] compose_pa(input logic [PPN_W-1:0] ppn,
                                                   input logic [VA_W-1:0]  va,
                                                   input logic [1:0]       level);
        logic [PA_W-1:0] mask;
        mask = (PA_W'(1) << (PAGE_OFF_W + LEVEL_BITS * level)) - PA_W'(1);
        return ({ppn, {PAGE_OFF_W{1'b0}}} & ~mask) | (PA_W'(va) & mask);
    endfunction

endpackage
